/* hw/vga_pkg.sv */
package vga_pkg;

  // column and row counters, enough for frames up to 1023 x 1023
  localparam int COORD_W = 10;

  // pattern codes taken from the low nibble of a received byte
  // codes 7 to 15 have no entry and show black
  typedef enum logic [3:0] {
    PAT_BLACK   = 4'd0,
    PAT_RED     = 4'd1,
    PAT_GREEN   = 4'd2,
    PAT_BLUE    = 4'd3,
    PAT_CHECKER = 4'd4,
    PAT_BARS    = 4'd5,
    PAT_BORDER  = 4'd6
  } pattern_e;

  // uart receiver states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

/* hw/vga_timing_if.sv */
`timescale 1ns/1ns

// recovered syncs with the matching column and row
interface vga_timing_if;
  import vga_pkg::*;

  logic               hsync;
  logic               vsync;
  logic [COORD_W-1:0] col;
  logic [COORD_W-1:0] row;

  // sync recovery side
  modport source (
    output hsync, vsync, col, row
  );

  // pattern generator side
  modport sink (
    input hsync, vsync, col, row
  );

endinterface

/* hw/sync_gen.sv */
`timescale 1ns/1ns

module sync_gen #(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic clk,
  input  logic i_reset,
  output logic o_hsync,
  output logic o_vsync
);
  import vga_pkg::*;

  logic [COORD_W-1:0] col_q;
  logic [COORD_W-1:0] row_q;

  // counters run one pixel ahead of the registered syncs
  always_ff @(posedge clk) begin
    if (i_reset) begin
      col_q   <= '0;
      row_q   <= '0;
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
    end else begin
      o_hsync <= (col_q < ACTIVE_COLS);
      o_vsync <= (row_q < ACTIVE_ROWS);
      if (col_q == COORD_W'(TOTAL_COLS - 1)) begin
        col_q <= '0;
        // row steps on column wrap
        if (row_q == COORD_W'(TOTAL_ROWS - 1)) begin
          row_q <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  a_col_in_frame : assert property (
    @(posedge clk) disable iff (i_reset)
    col_q < TOTAL_COLS
  ) else $error("sync_gen column count left the frame");

endmodule

/* hw/sync_count.sv */
`timescale 1ns/1ns

module sync_count #(
  parameter int TOTAL_COLS = 800,
  parameter int TOTAL_ROWS = 525
) (
  input  logic         clk,
  input  logic         i_reset,
  input  logic         i_hsync,
  input  logic         i_vsync,
  vga_timing_if.source o_timing
);
  import vga_pkg::*;

  logic vsync_rise;

  // delayed vsync doubles as the previous value for edge detection
  assign vsync_rise = i_vsync & ~o_timing.vsync;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_timing.hsync <= 1'b0;
      o_timing.vsync <= 1'b0;
      o_timing.col   <= '0;
      o_timing.row   <= '0;
    end else begin
      o_timing.hsync <= i_hsync;
      o_timing.vsync <= i_vsync;
      if (vsync_rise) begin
        // first active pixel of a new frame
        o_timing.col <= '0;
        o_timing.row <= '0;
      end else if (o_timing.col == COORD_W'(TOTAL_COLS - 1)) begin
        o_timing.col <= '0;
        if (o_timing.row == COORD_W'(TOTAL_ROWS - 1)) begin
          o_timing.row <= '0;
        end else begin
          o_timing.row <= o_timing.row + 1'b1;
        end
      end else begin
        o_timing.col <= o_timing.col + 1'b1;
      end
    end
  end

  a_row_in_frame : assert property (
    @(posedge clk) disable iff (i_reset)
    o_timing.row < TOTAL_ROWS
  ) else $error("sync_count row count left the frame");

endmodule

/* hw/pattern_gen.sv */
`timescale 1ns/1ns

module pattern_gen #(
  parameter int VIDEO_WIDTH  = 3,
  parameter int ACTIVE_COLS  = 640,
  parameter int ACTIVE_ROWS  = 480,
  parameter int CHECKER_LOG2 = 5
) (
  input  logic                   clk,
  input  logic                   i_reset,
  vga_timing_if.sink             i_timing,
  input  logic                   i_rx_valid,
  input  logic [7:0]             i_rx_byte,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic [VIDEO_WIDTH-1:0] o_r_val,
  output logic [VIDEO_WIDTH-1:0] o_g_val,
  output logic [VIDEO_WIDTH-1:0] o_b_val
);
  import vga_pkg::*;

  localparam int BAR_W = ACTIVE_COLS / 8;
  localparam logic [VIDEO_WIDTH-1:0] FULL = '1;

  pattern_e               pattern_q;
  logic                   active;
  logic                   checker_on;
  logic                   border_on;
  logic [2:0]             bar_sel;
  logic [VIDEO_WIDTH-1:0] r_next;
  logic [VIDEO_WIDTH-1:0] g_next;
  logic [VIDEO_WIDTH-1:0] b_next;

  // inside the active area both sync levels are high
  assign active = i_timing.hsync & i_timing.vsync;

  assign checker_on = i_timing.col[CHECKER_LOG2] ^ i_timing.row[CHECKER_LOG2];

  assign border_on = (i_timing.row <= 1) || (i_timing.row >= ACTIVE_ROWS - 2) ||
                     (i_timing.col <= 1) || (i_timing.col >= ACTIVE_COLS - 2);

  // bar index from the column, eight equal bars
  always_comb begin
    bar_sel = 3'd0;
    for (int i = 1; i < 8; i++) begin
      if (i_timing.col >= COORD_W'(i * BAR_W)) begin
        bar_sel = 3'(i);
      end
    end
  end

  always_comb begin
    r_next = '0;
    g_next = '0;
    b_next = '0;
    if (active) begin
      case (pattern_q)
        PAT_RED: begin
          r_next = FULL;
        end
        PAT_GREEN: begin
          g_next = FULL;
        end
        PAT_BLUE: begin
          b_next = FULL;
        end
        PAT_CHECKER: begin
          r_next = {VIDEO_WIDTH{checker_on}};
          g_next = {VIDEO_WIDTH{checker_on}};
          b_next = {VIDEO_WIDTH{checker_on}};
        end
        PAT_BARS: begin
          // bar index bits map straight onto r, g, b
          r_next = {VIDEO_WIDTH{bar_sel[2]}};
          g_next = {VIDEO_WIDTH{bar_sel[1]}};
          b_next = {VIDEO_WIDTH{bar_sel[0]}};
        end
        PAT_BORDER: begin
          r_next = {VIDEO_WIDTH{border_on}};
          g_next = {VIDEO_WIDTH{border_on}};
          b_next = {VIDEO_WIDTH{border_on}};
        end
        default: begin
          // black, also for the unused codes
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pattern_q <= PAT_BLACK;
      o_hsync   <= 1'b0;
      o_vsync   <= 1'b0;
      o_r_val   <= '0;
      o_g_val   <= '0;
      o_b_val   <= '0;
    end else begin
      if (i_rx_valid) begin
        pattern_q <= pattern_e'(i_rx_byte[3:0]);
      end
      o_hsync <= i_timing.hsync;
      o_vsync <= i_timing.vsync;
      o_r_val <= r_next;
      o_g_val <= g_next;
      o_b_val <= b_next;
    end
  end

  a_blank_outside : assert property (
    @(posedge clk) disable iff (i_reset)
    !(o_hsync && o_vsync) |-> (o_r_val == '0 && o_g_val == '0 && o_b_val == '0)
  ) else $error("pattern_gen drives colour during blanking");

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_rx,
  output logic       o_rx_valid,
  output logic [7:0] o_rx_byte
);
  import vga_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  rx_state_e  state_q;
  logic [1:0] rx_meta;
  logic       rx_s;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0] bit_idx_q;
  logic [7:0] shift_q;

  // two flops on the asynchronous serial line
  always_ff @(posedge clk) begin
    rx_meta <= {rx_meta[0], i_rx};
  end
  assign rx_s = rx_meta[1];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q    <= RX_IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // middle of the start bit, drop glitches
          if (cnt_q == CNT_W'((CLKS_PER_BIT - 1) / 2)) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            // a low stop bit is a framing error, byte dropped
            o_rx_valid <= rx_s;
            state_q    <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign o_rx_byte = shift_q;

  a_valid_pulse : assert property (
    @(posedge clk) disable iff (i_reset)
    o_rx_valid |=> !o_rx_valid
  ) else $error("uart_rx valid held for more than one cycle");

endmodule

/* hw/vga_test_top.sv */
`timescale 1ns/1ns

module vga_test_top #(
  parameter int VIDEO_WIDTH  = 3,
  parameter int TOTAL_COLS   = 800,
  parameter int TOTAL_ROWS   = 525,
  parameter int ACTIVE_COLS  = 640,
  parameter int ACTIVE_ROWS  = 480,
  parameter int CHECKER_LOG2 = 5,
  parameter int CLKS_PER_BIT = 217
) (
  input  logic                   clk,
  input  logic                   i_reset,
  input  logic                   i_uart_rx,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic [VIDEO_WIDTH-1:0] o_r_val,
  output logic [VIDEO_WIDTH-1:0] o_g_val,
  output logic [VIDEO_WIDTH-1:0] o_b_val
);

  logic       gen_hsync;
  logic       gen_vsync;
  logic       rx_valid;
  logic [7:0] rx_byte;

  vga_timing_if timing ();

  sync_gen #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) sync_gen0 (
    .clk     (clk),
    .i_reset (i_reset),
    .o_hsync (gen_hsync),
    .o_vsync (gen_vsync)
  );

  // rebuild counters from the sync levels
  sync_count #(
    .TOTAL_COLS (TOTAL_COLS),
    .TOTAL_ROWS (TOTAL_ROWS)
  ) sync_count0 (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_hsync  (gen_hsync),
    .i_vsync  (gen_vsync),
    .o_timing (timing.source)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_rx0 (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_rx       (i_uart_rx),
    .o_rx_valid (rx_valid),
    .o_rx_byte  (rx_byte)
  );

  pattern_gen #(
    .VIDEO_WIDTH  (VIDEO_WIDTH),
    .ACTIVE_COLS  (ACTIVE_COLS),
    .ACTIVE_ROWS  (ACTIVE_ROWS),
    .CHECKER_LOG2 (CHECKER_LOG2)
  ) pattern_gen0 (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_timing   (timing.sink),
    .i_rx_valid (rx_valid),
    .i_rx_byte  (rx_byte),
    .o_hsync    (o_hsync),
    .o_vsync    (o_vsync),
    .o_r_val    (o_r_val),
    .o_g_val    (o_g_val),
    .o_b_val    (o_b_val)
  );

endmodule

/* verification/tb_vga_test.sv */
`timescale 1ns/1ns

module tb_vga_test;
  import vga_pkg::*;

  localparam int VIDEO_WIDTH  = 3;
  localparam int TOTAL_COLS   = 20;
  localparam int TOTAL_ROWS   = 12;
  localparam int ACTIVE_COLS  = 16;
  localparam int ACTIVE_ROWS  = 8;
  localparam int CHECKER_LOG2 = 2;
  localparam int CLKS_PER_BIT = 8;
  localparam int FRAME_CYCLES = TOTAL_COLS * TOTAL_ROWS;
  localparam int WAIT_LIMIT   = 4 * FRAME_CYCLES;

  logic                   clk = 1'b0;
  logic                   i_reset;
  logic                   i_uart_rx;
  logic                   o_hsync;
  logic                   o_vsync;
  logic [VIDEO_WIDTH-1:0] o_r_val;
  logic [VIDEO_WIDTH-1:0] o_g_val;
  logic [VIDEO_WIDTH-1:0] o_b_val;

  int   errors    = 0;
  int   checks    = 0;
  logic timed_out = 1'b0;

  vga_test_top #(
    .VIDEO_WIDTH  (VIDEO_WIDTH),
    .TOTAL_COLS   (TOTAL_COLS),
    .TOTAL_ROWS   (TOTAL_ROWS),
    .ACTIVE_COLS  (ACTIVE_COLS),
    .ACTIVE_ROWS  (ACTIVE_ROWS),
    .CHECKER_LOG2 (CHECKER_LOG2),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut0 (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_uart_rx (i_uart_rx),
    .o_hsync   (o_hsync),
    .o_vsync   (o_vsync),
    .o_r_val   (o_r_val),
    .o_g_val   (o_g_val),
    .o_b_val   (o_b_val)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before && !timed_out) begin
      $display("%s: done, no errors", name);
    end else begin
      $display("%s: done with %0d errors", name, errors - errors_before);
    end
  endtask

  // expected {r,g,b} on/off flags for one pixel
  function automatic logic [2:0] pixel_model(input logic [3:0] pat, input int col,
                                             input int row);
    logic [2:0] rgb;
    int         bar;
    rgb = 3'b000;
    bar = col / (ACTIVE_COLS / 8);
    if (col < ACTIVE_COLS && row < ACTIVE_ROWS) begin
      case (pat)
        PAT_RED:   rgb = 3'b100;
        PAT_GREEN: rgb = 3'b010;
        PAT_BLUE:  rgb = 3'b001;
        PAT_CHECKER: begin
          if ((((col >> CHECKER_LOG2) ^ (row >> CHECKER_LOG2)) & 1) == 1) begin
            rgb = 3'b111;
          end
        end
        PAT_BARS: rgb = bar[2:0];
        PAT_BORDER: begin
          if (col < 2 || col >= ACTIVE_COLS - 2 || row < 2 || row >= ACTIVE_ROWS - 2) begin
            rgb = 3'b111;
          end
        end
        default: rgb = 3'b000;
      endcase
    end
    return rgb;
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // 8N1 frame with the lsb first
  task automatic send_byte(input logic [7:0] data);
    i_uart_rx = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      i_uart_rx = data[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    i_uart_rx = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  // returns at the negedge where o_vsync has just risen on pixel (0,0)
  task automatic wait_frame(output int cycles);
    logic prev;
    cycles = 0;
    prev   = 1'b1;
    if (!timed_out) begin
      do begin
        prev = o_vsync;
        @(negedge clk);
        cycles++;
      end while (!(o_vsync && !prev) && cycles < WAIT_LIMIT);
      if (!(o_vsync && !prev)) begin
        timed_out = 1'b1;
        $display("timeout: o_vsync did not rise within %0d cycles", WAIT_LIMIT);
      end
    end
  endtask

  task automatic check_frame(input logic [3:0] pat);
    logic [2:0] rgb;
    if (!timed_out) begin
      for (int row = 0; row < TOTAL_ROWS; row++) begin
        for (int col = 0; col < TOTAL_COLS; col++) begin
          rgb = pixel_model(pat, col, row);
          check_value("o_hsync", o_hsync, col < ACTIVE_COLS);
          check_value("o_vsync", o_vsync, row < ACTIVE_ROWS);
          check_value("o_r_val", o_r_val, {VIDEO_WIDTH{rgb[2]}});
          check_value("o_g_val", o_g_val, {VIDEO_WIDTH{rgb[1]}});
          check_value("o_b_val", o_b_val, {VIDEO_WIDTH{rgb[0]}});
          @(negedge clk);
        end
      end
    end
  endtask

  task automatic select_and_check(input logic [7:0] data);
    int cycles;
    send_byte(data);
    wait_frame(cycles);
    check_frame(data[3:0]);
  endtask

  task automatic test_reset();
    int errors_before;
    int cycles;
    errors_before = errors;
    i_reset = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value("o_hsync", o_hsync, 0);
      check_value("o_vsync", o_vsync, 0);
      check_value("o_r_val", o_r_val, 0);
      check_value("o_g_val", o_g_val, 0);
      check_value("o_b_val", o_b_val, 0);
    end
    i_reset = 1'b0;
    // idle line keeps the pattern register at black
    wait_frame(cycles);
    check_frame(4'd0);
    report_test("reset", errors_before);
  endtask

  task automatic test_sync_timing();
    int errors_before;
    int cycles;
    errors_before = errors;
    wait_frame(cycles);
    check_frame(4'd0);
    wait_frame(cycles);
    if (!timed_out) begin
      check_value("o_vsync period", cycles, FRAME_CYCLES);
    end
    report_test("sync timing", errors_before);
  endtask

  task automatic test_solid();
    int errors_before;
    errors_before = errors;
    select_and_check(8'h01);
    select_and_check(8'h02);
    select_and_check(8'h03);
    select_and_check(8'h00);
    report_test("solid patterns", errors_before);
  endtask

  task automatic test_checker_bars();
    int errors_before;
    errors_before = errors;
    select_and_check(8'h04);
    select_and_check(8'h05);
    report_test("checkerboard and bars", errors_before);
  endtask

  task automatic test_border_rules();
    int errors_before;
    errors_before = errors;
    select_and_check(8'h06);
    // upper nibble is ignored
    select_and_check(8'h35);
    select_and_check(8'h07);
    select_and_check(8'h0f);
    report_test("border and selection rules", errors_before);
  endtask

  task automatic test_random();
    int          errors_before;
    logic [31:0] state;
    errors_before = errors;
    state = 32'h385d;
    repeat (10) begin
      state = next_random(state);
      select_and_check(state[23:16]);
    end
    report_test("random selection", errors_before);
  endtask

  initial begin
    i_reset   = 1'b1;
    i_uart_rx = 1'b1;
    test_reset();
    test_sync_timing();
    test_solid();
    test_checker_bars();
    test_border_rules();
    test_random();
    $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* vga_test.f */
hw/vga_pkg.sv
hw/vga_timing_if.sv
hw/sync_gen.sv
hw/sync_count.sv
hw/pattern_gen.sv
hw/uart_rx.sv
hw/vga_test_top.sv
verification/tb_vga_test.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the VGA test pattern testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vga_test -f vga_test.f -o tb_vga_test || exit 1

sim_out="$(./obj_dir/tb_vga_test)"
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && exit 0 || exit 1
